// File: qbus_settings.svh
// ==================================================
// Q-bus subsystem settings
// timeout, RAM window and delay, INIT length and
// the two system register addresses
// ==================================================
`ifndef QBUS_SETTINGS_SVH
`define QBUS_SETTINGS_SVH

// bus master
`define QBUS_TIMEOUT     16        // cycles without RPLY before error
`define INIT_CYCLES      10        // peripheral INIT length

// word RAM slave
`define RAM_BASE         16'o100000
`define RAM_WORDS        256
`define RAM_REPLY_DELAY  2         // DIN/DOUT to RPLY

// system registers, no RPLY
`define SEL1_ADDR        16'o177716
`define SEL2_ADDR        16'o177714

`endif

// File: qbus_pkg.sv
// ==================================================
// Q-bus shared types
// core request, core response and bus controls
// ==================================================
package qbus_pkg;

	// one core request
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        write;    // DATO when set, else DATI
		logic        byte_op;  // byte access
	} bus_req_t;

	// one completed cycle
	typedef struct packed {
		logic [15:0] rdata;
		logic        error;    // no RPLY within timeout
	} bus_rsp_t;

	// master controls seen by every slave
	typedef struct packed {
		logic sync;
		logic din;
		logic dout;
		logic wtbt;            // byte write
	} bus_ctl_t;

endpackage

// File: request_latch.sv
// ==================================================
// Core request latch
// holds one request while the bus cycle runs and
// moves byte write data onto the odd lane
// ==================================================
`timescale 1ns/1ps

module request_latch (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               req_valid_i,
	input  qbus_pkg::bus_req_t req_i,
	input  logic               cycle_end_i,
	input  logic               rsp_done_i,
	output qbus_pkg::bus_req_t held_req_o,
	output logic               req_pending_o,
	output logic               busy_o
);

	logic busy_q;
	logic accept;

	assign accept = req_valid_i & ~busy_o;      // strobes while busy are dropped
	assign busy_o = busy_q & ~rsp_done_i;       // released in the done cycle

	// ==================================================
	// control state
	// ==================================================
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy_q        <= 1'b0;
			req_pending_o <= 1'b0;
		end else if (accept) begin
			busy_q        <= 1'b1;
			req_pending_o <= 1'b1;
		end else begin
			if (rsp_done_i) begin
				busy_q <= 1'b0;
			end
			if (cycle_end_i) begin
				req_pending_o <= 1'b0;          // bus cycle finished
			end
		end
	end

	// request payload
	always_ff @(posedge clk) begin
		if (accept) begin
			held_req_o <= req_i;
			if (req_i.write && req_i.byte_op && req_i.addr[0]) begin
				held_req_o.wdata <= {req_i.wdata[7:0], req_i.wdata[7:0]};  // odd lane
			end
		end
	end

endmodule

// File: bus_cycle_ctl.sv
// ==================================================
// Q-bus master sequencer
// runs DATI/DATO with SYNC, DIN, DOUT and RPLY,
// decodes SEL1/SEL2, times out and stretches INIT
// ==================================================
`timescale 1ns/1ps
`include "qbus_settings.svh"

module bus_cycle_ctl (
	input  logic               clk,
	input  logic               reset_n,
	input  qbus_pkg::bus_req_t held_req_i,
	input  logic               req_pending_i,
	input  logic               rply_i,
	input  logic               init_req_i,
	output qbus_pkg::bus_ctl_t bus_ctl_o,
	output logic [15:0]        bus_addr_o,
	output logic [15:0]        bus_wdata_o,
	output logic               sel1_o,
	output logic               sel2_o,
	output logic               cycle_end_o,
	output logic               cycle_err_o,
	output logic               init_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_END} state_t;

	localparam int TW = $clog2(`QBUS_TIMEOUT + 1);
	localparam int IW = $clog2(`INIT_CYCLES + 1);
	localparam logic [15:0] SEL1 = `SEL1_ADDR;
	localparam logic [15:0] SEL2 = `SEL2_ADDR;

	state_t        state;
	logic [TW-1:0] wait_cnt;
	logic [IW-1:0] init_cnt;
	logic          in_data;
	logic          sel1_hit;
	logic          sel2_hit;
	logic          sel_cycle;
	logic          timed_out;

	// ==================================================
	// bus signals
	// ==================================================
	assign in_data     = (state == ST_DATA);
	assign bus_addr_o  = held_req_i.addr;
	assign bus_wdata_o = held_req_i.wdata;      // lane already steered

	assign bus_ctl_o.sync = (state == ST_ADDR) | in_data;
	assign bus_ctl_o.din  = in_data & ~held_req_i.write;
	assign bus_ctl_o.dout = in_data & held_req_i.write;
	assign bus_ctl_o.wtbt = bus_ctl_o.sync & held_req_i.write & held_req_i.byte_op;

	// system registers decode on the word address
	assign sel1_hit  = (held_req_i.addr[15:1] == SEL1[15:1]);
	assign sel2_hit  = (held_req_i.addr[15:1] == SEL2[15:1]);
	assign sel_cycle = sel1_hit | sel2_hit;
	assign sel1_o    = in_data & sel1_hit;
	assign sel2_o    = in_data & sel2_hit;

	assign timed_out   = (wait_cnt == TW'(`QBUS_TIMEOUT));
	assign cycle_end_o = in_data & (sel_cycle ? (wait_cnt == TW'(1)) : (rply_i | timed_out));
	assign cycle_err_o = in_data & ~sel_cycle & ~rply_i & timed_out;

	// ==================================================
	// cycle FSM
	// ==================================================
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state    <= ST_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_pending_i && !init_o) begin
						state <= ST_ADDR;       // address out with SYNC
					end
				end
				ST_ADDR: begin
					state    <= ST_DATA;
					wait_cnt <= '0;
				end
				ST_DATA: begin
					if (cycle_end_o) begin
						state <= ST_END;        // drop SYNC/DIN/DOUT together
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: begin
					if (!rply_i) begin
						state <= ST_IDLE;       // slave released RPLY
					end
				end
			endcase
		end
	end

	// peripheral INIT stretch
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			init_cnt <= '0;
		end else if (init_req_i) begin
			init_cnt <= IW'(`INIT_CYCLES);
		end else if (init_cnt != '0) begin
			init_cnt <= init_cnt - 1'b1;
		end
	end

	assign init_o = (init_cnt != '0);

endmodule

// File: bus_ram.sv
// ==================================================
// Q-bus word RAM slave
// answers in its own window with a fixed RPLY delay
// ==================================================
`timescale 1ns/1ps
`include "qbus_settings.svh"

module bus_ram (
	input  logic               clk,
	input  logic               reset_n,
	input  qbus_pkg::bus_ctl_t bus_ctl_i,
	input  logic [15:0]        bus_addr_i,
	input  logic [15:0]        bus_wdata_i,
	output logic               rply_o,
	output logic [15:0]        rdata_o
);

	localparam int AW = $clog2(`RAM_WORDS);
	localparam int DW = $clog2(`RAM_REPLY_DELAY + 1);
	localparam logic [15:0] RAM_LIMIT = 16'(`RAM_BASE + 2 * `RAM_WORDS);

	logic [15:0]   mem [`RAM_WORDS];
	logic [15:0]   offset;
	logic [AW-1:0] word_idx;
	logic [DW-1:0] dly_cnt;
	logic          hit;
	logic          active;

	assign hit      = bus_ctl_i.sync && (bus_addr_i >= `RAM_BASE) && (bus_addr_i < RAM_LIMIT);
	assign offset   = bus_addr_i - `RAM_BASE;
	assign word_idx = offset[AW:1];
	assign active   = hit & (bus_ctl_i.din | bus_ctl_i.dout);

	assign rply_o  = active & (dly_cnt == DW'(`RAM_REPLY_DELAY));  // falls with DIN/DOUT
	assign rdata_o = (hit & bus_ctl_i.din) ? mem[word_idx] : 16'h0000;

	// reply delay
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			dly_cnt <= '0;
		end else if (!active) begin
			dly_cnt <= '0;
		end else if (!rply_o) begin
			dly_cnt <= dly_cnt + 1'b1;
		end
	end

	// ==================================================
	// write port
	// ==================================================
	always_ff @(posedge clk) begin
		if (rply_o && bus_ctl_i.dout) begin
			if (!bus_ctl_i.wtbt) begin
				mem[word_idx] <= bus_wdata_i;
			end else if (bus_addr_i[0]) begin
				mem[word_idx][15:8] <= bus_wdata_i[15:8];  // odd byte
			end else begin
				mem[word_idx][7:0] <= bus_wdata_i[7:0];
			end
		end
	end

endmodule

// File: sys_port.sv
// ==================================================
// System registers on SEL1/SEL2
// read and written without RPLY, cleared by INIT
// ==================================================
`timescale 1ns/1ps

module sys_port (
	input  logic               clk,
	input  logic               reset_n,
	input  qbus_pkg::bus_ctl_t bus_ctl_i,
	input  logic               sel1_i,
	input  logic               sel2_i,
	input  logic [15:0]        bus_wdata_i,
	input  logic               bus_addr0_i,
	input  logic               init_i,
	output logic [15:0]        rdata_o
);

	logic [15:0] sel1_reg;
	logic [15:0] sel2_reg;
	logic        wr_en;
	logic        rd_en;

	// byte or word update of one register
	function automatic logic [15:0] merge_lanes(input logic [15:0] old_v,
	                                            input logic [15:0] new_v,
	                                            input logic        byte_wr,
	                                            input logic        odd);
		logic [15:0] v;
		v = new_v;
		if (byte_wr) begin
			v = odd ? {new_v[15:8], old_v[7:0]} : {old_v[15:8], new_v[7:0]};
		end
		return v;
	endfunction

	assign wr_en = bus_ctl_i.sync & bus_ctl_i.dout;
	assign rd_en = bus_ctl_i.sync & bus_ctl_i.din;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sel1_reg <= '0;
			sel2_reg <= '0;
		end else if (init_i) begin
			sel1_reg <= '0;                 // peripheral INIT
			sel2_reg <= '0;
		end else if (wr_en && sel1_i) begin
			sel1_reg <= merge_lanes(sel1_reg, bus_wdata_i, bus_ctl_i.wtbt, bus_addr0_i);
		end else if (wr_en && sel2_i) begin
			sel2_reg <= merge_lanes(sel2_reg, bus_wdata_i, bus_ctl_i.wtbt, bus_addr0_i);
		end
	end

	assign rdata_o = (rd_en & sel1_i) ? sel1_reg :
	                 (rd_en & sel2_i) ? sel2_reg : 16'h0000;

endmodule

// File: response_align.sv
// ==================================================
// Response path
// merges slave data, aligns bytes, registers result
// ==================================================
`timescale 1ns/1ps

module response_align (
	input  logic               clk,
	input  logic               reset_n,
	input  logic [15:0]        ram_rdata_i,
	input  logic [15:0]        sys_rdata_i,
	input  logic               cycle_end_i,
	input  logic               cycle_err_i,
	input  logic               byte_op_i,
	input  logic               addr0_i,
	output logic               done_o,
	output qbus_pkg::bus_rsp_t rsp_o
);

	logic [15:0] merged;
	logic [15:0] aligned;

	assign merged = ram_rdata_i | sys_rdata_i;  // idle slaves drive zero

	always_comb begin
		if (cycle_err_i) begin
			aligned = 16'h0000;
		end else if (byte_op_i) begin
			aligned = addr0_i ? {8'h00, merged[15:8]} : {8'h00, merged[7:0]};
		end else begin
			aligned = merged;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			done_o <= 1'b0;
		end else begin
			done_o <= cycle_end_i;
		end
	end

	// held until the next cycle end
	always_ff @(posedge clk) begin
		if (cycle_end_i) begin
			rsp_o.rdata <= aligned;
			rsp_o.error <= cycle_err_i;
		end
	end

endmodule

// File: qbus_top.sv
// ==================================================
// Q-bus master with RAM and system register slaves
// core request port in, response and bus view out
// ==================================================
`timescale 1ns/1ps

module qbus_top (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               req_valid_i,
	input  qbus_pkg::bus_req_t req_i,
	input  logic               init_req_i,
	output logic               busy_o,
	output logic               done_o,
	output qbus_pkg::bus_rsp_t rsp_o,
	output logic               init_o,
	output qbus_pkg::bus_ctl_t bus_ctl_o
);

	qbus_pkg::bus_req_t held_req;
	qbus_pkg::bus_ctl_t bus_ctl;
	logic               req_pending;
	logic               cycle_end;
	logic               cycle_err;
	logic [15:0]        bus_addr;
	logic [15:0]        bus_wdata;
	logic               sel1;
	logic               sel2;
	logic               init;
	logic               ram_rply;
	logic [15:0]        ram_rdata;
	logic [15:0]        sys_rdata;

	assign bus_ctl_o = bus_ctl;
	assign init_o    = init;

	// ==================================================
	// input side and bus master
	// ==================================================
	request_latch i_request_latch (
		.clk          (clk),
		.reset_n      (reset_n),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.cycle_end_i  (cycle_end),
		.rsp_done_i   (done_o),
		.held_req_o   (held_req),
		.req_pending_o(req_pending),
		.busy_o       (busy_o)
	);

	bus_cycle_ctl i_bus_cycle_ctl (
		.clk          (clk),
		.reset_n      (reset_n),
		.held_req_i   (held_req),
		.req_pending_i(req_pending),
		.rply_i       (ram_rply),          // only the RAM replies
		.init_req_i   (init_req_i),
		.bus_ctl_o    (bus_ctl),
		.bus_addr_o   (bus_addr),
		.bus_wdata_o  (bus_wdata),
		.sel1_o       (sel1),
		.sel2_o       (sel2),
		.cycle_end_o  (cycle_end),
		.cycle_err_o  (cycle_err),
		.init_o       (init)
	);

	// ==================================================
	// slaves and response path
	// ==================================================
	bus_ram i_bus_ram (
		.clk        (clk),
		.reset_n    (reset_n),
		.bus_ctl_i  (bus_ctl),
		.bus_addr_i (bus_addr),
		.bus_wdata_i(bus_wdata),
		.rply_o     (ram_rply),
		.rdata_o    (ram_rdata)
	);

	sys_port i_sys_port (
		.clk        (clk),
		.reset_n    (reset_n),
		.bus_ctl_i  (bus_ctl),
		.sel1_i     (sel1),
		.sel2_i     (sel2),
		.bus_wdata_i(bus_wdata),
		.bus_addr0_i(bus_addr[0]),
		.init_i     (init),
		.rdata_o    (sys_rdata)
	);

	response_align i_response_align (
		.clk        (clk),
		.reset_n    (reset_n),
		.ram_rdata_i(ram_rdata),
		.sys_rdata_i(sys_rdata),
		.cycle_end_i(cycle_end),
		.cycle_err_i(cycle_err),
		.byte_op_i  (held_req.byte_op),
		.addr0_i    (held_req.addr[0]),
		.done_o     (done_o),
		.rsp_o      (rsp_o)
	);

endmodule

// File: tb_qbus_top.sv
// ==================================================
// Q-bus subsystem testbench
// table driven DATI/DATO, SEL and INIT checks
// against a shadow model of RAM and registers
// ==================================================
`timescale 1ns/1ps
`include "qbus_settings.svh"

module tb_qbus_top;

	localparam logic [1:0]  K_REQ     = 2'd0;
	localparam logic [1:0]  K_INIT    = 2'd1;
	localparam logic [1:0]  K_DUP     = 2'd2;    // request plus a strobe while busy
	localparam logic [15:0] SEL1_A    = `SEL1_ADDR;
	localparam logic [15:0] SEL2_A    = `SEL2_ADDR;
	localparam logic [15:0] RAM_LO    = `RAM_BASE;
	localparam int          RAM_BYTES = 2 * `RAM_WORDS;
	localparam int          AW        = $clog2(`RAM_WORDS);

	typedef struct packed {
		logic [1:0]  kind;
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        write;
		logic        byte_op;
		logic [15:0] exp_rdata;
		logic        exp_error;
	} entry_t;

	logic               clk;
	logic               reset_n;
	logic               req_valid_i;
	logic               init_req_i;
	logic               busy_o;
	logic               done_o;
	logic               init_o;
	qbus_pkg::bus_req_t req_i;
	qbus_pkg::bus_rsp_t rsp_o;
	qbus_pkg::bus_ctl_t bus_ctl_o;

	entry_t      table_q[$];
	logic [15:0] shadow_ram [`RAM_WORDS];
	logic [15:0] shadow_sel1;
	logic [15:0] shadow_sel2;
	integer      seed;
	int          cycle_cnt;
	int          cycle_limit;

	qbus_top i_qbus_top (
		.clk        (clk),
		.reset_n    (reset_n),
		.req_valid_i(req_valid_i),
		.req_i      (req_i),
		.init_req_i (init_req_i),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.rsp_o      (rsp_o),
		.init_o     (init_o),
		.bus_ctl_o  (bus_ctl_o)
	);

	always #4 clk = ~clk;                        // 8 ns period

	// run length guard
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("TIMEOUT: run did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	function automatic logic [15:0] next_word();
		return 16'($random(seed));
	endfunction

	// ==================================================
	// shadow model
	// ==================================================
	// 0 RAM, 1 SEL1, 2 SEL2, 3 nobody replies
	function automatic int decode(input logic [15:0] a);
		if (a >= RAM_LO && 32'(a) < 32'(RAM_LO) + RAM_BYTES) return 0;
		if (a[15:1] == SEL1_A[15:1]) return 1;
		if (a[15:1] == SEL2_A[15:1]) return 2;
		return 3;
	endfunction

	task automatic model_access(input logic [15:0] addr, input logic [15:0] wdata,
	                            input logic write, input logic byte_op,
	                            output logic [15:0] rdata, output logic err);
		logic [15:0]   word;
		logic [AW-1:0] idx;
		int            target;
		target = decode(addr);
		idx    = AW'((addr - RAM_LO) >> 1);
		rdata  = 16'h0000;
		err    = (target == 3);
		case (target)
			0:       word = shadow_ram[idx];
			1:       word = shadow_sel1;
			2:       word = shadow_sel2;
			default: word = 16'h0000;
		endcase
		if (!err && write) begin
			if (!byte_op) word = wdata;
			else if (addr[0]) word[15:8] = wdata[7:0];   // core byte goes to the odd lane
			else word[7:0] = wdata[7:0];
			case (target)
				0:       shadow_ram[idx] = word;
				1:       shadow_sel1 = word;
				default: shadow_sel2 = word;
			endcase
		end else if (!err) begin
			if (!byte_op) rdata = word;
			else rdata = addr[0] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
		end
	endtask

	task automatic add_entry(input logic [1:0] kind, input logic [15:0] addr,
	                         input logic [15:0] wdata, input logic write, input logic byte_op);
		entry_t e;
		e = '0;
		e.kind    = kind;
		e.addr    = addr;
		e.wdata   = wdata;
		e.write   = write;
		e.byte_op = byte_op;
		if (kind == K_INIT) begin
			shadow_sel1 = 16'h0000;                  // INIT clears both registers
			shadow_sel2 = 16'h0000;
		end else begin
			model_access(addr, wdata, write, byte_op, e.exp_rdata, e.exp_error);
		end
		table_q.push_back(e);
	endtask

	// clock edges after the drive edge until done_o is seen
	function automatic int expected_latency(input entry_t e);
		if (e.exp_error) return 3 + `QBUS_TIMEOUT + 1;
		if (decode(e.addr) != 0) return 3 + 1 + 1;
		return 3 + `RAM_REPLY_DELAY + 1;
	endfunction

	task automatic build_table();
		add_entry(K_REQ, RAM_LO + 16'h0010, next_word(), 1'b1, 1'b0);   // word write/read
		add_entry(K_REQ, RAM_LO + 16'h0010, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, RAM_LO + 16'h0012, next_word(), 1'b1, 1'b0);
		add_entry(K_REQ, RAM_LO + 16'h0013, next_word(), 1'b1, 1'b1);   // odd byte write
		add_entry(K_REQ, RAM_LO + 16'h0012, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, RAM_LO + 16'h0014, next_word(), 1'b1, 1'b0);
		add_entry(K_REQ, RAM_LO + 16'h0014, next_word(), 1'b1, 1'b1);   // even byte write
		add_entry(K_REQ, RAM_LO + 16'h0014, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, RAM_LO + 16'h0013, 16'h0000, 1'b0, 1'b1);      // byte reads
		add_entry(K_REQ, RAM_LO + 16'h0012, 16'h0000, 1'b0, 1'b1);
		add_entry(K_REQ, RAM_LO + 16'(RAM_BYTES - 2), next_word(), 1'b1, 1'b0);
		add_entry(K_REQ, RAM_LO + 16'(RAM_BYTES - 2), 16'h0000, 1'b0, 1'b0);
		// system registers
		add_entry(K_REQ, SEL1_A, next_word(), 1'b1, 1'b0);
		add_entry(K_REQ, SEL2_A, next_word(), 1'b1, 1'b0);
		add_entry(K_REQ, SEL1_A, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, SEL2_A, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, SEL1_A | 16'h0001, next_word(), 1'b1, 1'b1);
		add_entry(K_REQ, SEL1_A, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, SEL2_A | 16'h0001, 16'h0000, 1'b0, 1'b1);
		// no reply
		add_entry(K_REQ, 16'h4000, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, RAM_LO + 16'(RAM_BYTES), next_word(), 1'b1, 1'b0);
		add_entry(K_REQ, RAM_LO - 16'd2, 16'h0000, 1'b0, 1'b0);
		// strobe while busy, then confirm the word is unchanged
		add_entry(K_DUP, RAM_LO + 16'h0010, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, RAM_LO + 16'h0010, 16'h0000, 1'b0, 1'b0);
		// INIT clears registers only
		add_entry(K_INIT, 16'h0000, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, SEL1_A, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, SEL2_A, 16'h0000, 1'b0, 1'b0);
		add_entry(K_REQ, RAM_LO + 16'h0012, 16'h0000, 1'b0, 1'b0);
	endtask

	// ==================================================
	// drivers
	// ==================================================
	task automatic run_request(input entry_t e);
		int                 n;
		int                 lat;
		logic               got;
		qbus_pkg::bus_ctl_t exp_ctl;
		lat = expected_latency(e);
		@(posedge clk);
		#1;
		req_i.addr    = e.addr;
		req_i.wdata   = e.wdata;
		req_i.write   = e.write;
		req_i.byte_op = e.byte_op;
		req_valid_i   = 1'b1;
		n   = 0;
		got = 1'b0;
		while (!got) begin
			@(negedge clk);
			exp_ctl.sync = (n >= 2) && (n < lat);        // address phase onwards
			exp_ctl.din  = exp_ctl.sync && (n >= 3) && !e.write;
			exp_ctl.dout = exp_ctl.sync && (n >= 3) && e.write;
			exp_ctl.wtbt = exp_ctl.sync && e.write && e.byte_op;
			check_val("bus_ctl_o", 32'(bus_ctl_o), 32'(exp_ctl));
			if (done_o) got = 1'b1;
			else if (n >= 1) check_val("busy_o", 32'(busy_o), 32'd1);
			if (!got) begin
				@(posedge clk);
				#1;
				n++;
				req_valid_i = (e.kind == K_DUP) && (n == 2);   // second strobe, busy high
				if (req_valid_i) begin
					req_i.write   = 1'b1;
					req_i.byte_op = 1'b0;
					req_i.wdata   = ~e.exp_rdata;
				end
			end
		end
		check_val("done_o latency", 32'(n), 32'(lat));
		check_val("busy_o", 32'(busy_o), 32'd0);             // falls with done
		check_val("rsp_o.rdata", 32'(rsp_o.rdata), 32'(e.exp_rdata));
		check_val("rsp_o.error", 32'(rsp_o.error), 32'(e.exp_error));
		@(negedge clk);
		check_val("done_o", 32'(done_o), 32'd0);
		if (e.kind == K_DUP) begin
			repeat (`QBUS_TIMEOUT + 8) begin
				@(negedge clk);
				check_val("done_o", 32'(done_o), 32'd0);     // ignored strobe, no done
				check_val("busy_o", 32'(busy_o), 32'd0);
				check_val("bus_ctl_o", 32'(bus_ctl_o), 32'd0);
			end
		end
	endtask

	task automatic run_init();
		int high_cnt;
		@(posedge clk);
		#1;
		init_req_i = 1'b1;
		check_val("init_o", 32'(init_o), 32'd0);
		@(posedge clk);
		#1;
		init_req_i = 1'b0;
		check_val("init_o", 32'(init_o), 32'd1);             // high the cycle after
		high_cnt = 0;
		@(negedge clk);
		while (init_o) begin
			high_cnt++;
			@(negedge clk);
		end
		check_val("init_o length", 32'(high_cnt), 32'(`INIT_CYCLES));
	endtask

	initial begin
		clk         = 1'b0;
		reset_n     = 1'b0;
		req_valid_i = 1'b0;
		req_i       = '0;
		init_req_i  = 1'b0;
		seed        = 32'hc1d2_f703;
		cycle_cnt   = 0;
		shadow_sel1 = 16'h0000;
		shadow_sel2 = 16'h0000;
		build_table();
		cycle_limit = table_q.size() * (`QBUS_TIMEOUT + 8) + 50;
		repeat (3) @(posedge clk);
		#1;
		reset_n = 1'b1;
		foreach (table_q[i]) begin
			if (table_q[i].kind == K_INIT) run_init();
			else run_request(table_q[i]);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: src.f
+incdir+.
qbus_pkg.sv
request_latch.sv
bus_cycle_ctl.sv
bus_ram.sv
sys_port.sv
response_align.sv
qbus_top.sv
tb_qbus_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_qbus_top
RTL_TOP   := qbus_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
